//--- hdl/fbuf_pkg.sv
package fbuf_pkg;

	// Pixel and memory word width
	parameter int DATA_W = 16;

	// Word address into the shared frame memory
	parameter int ADDR_W = 8;

	// Two readers plus writer plus one spare
	parameter int NUM_BUFS = 4;

	// Memory clients on the arbiter
	parameter int NUM_PORTS = 3;

	// One bit per frame buffer
	typedef logic [NUM_BUFS-1:0] bmp_t;

	// Arbiter client numbering
	typedef enum logic [1:0] {
		WRITER  = 2'd0,
		READER0 = 2'd1,
		READER1 = 2'd2
	} port_id_t;

endpackage

//--- hdl/mutex_buffer_ctl.sv
`timescale 1ns/1ps

module mutex_buffer_ctl #(
	parameter int FRAME_WORDS = 16
) (
	input  logic                        clk,
	input  logic                        resetn,

	input  logic                        w_sof,
	input  logic                        r0_sof,
	input  logic                        r1_sof,

	output logic [fbuf_pkg::ADDR_W-1:0] w_addr,
	output logic [fbuf_pkg::ADDR_W-1:0] r0_addr,
	output logic [fbuf_pkg::ADDR_W-1:0] r1_addr
);

	localparam int NUM_READERS = 2;
	localparam int IDX_W = $clog2(fbuf_pkg::NUM_BUFS);

	fbuf_pkg::bmp_t              w_bmp;
	fbuf_pkg::bmp_t              last_bmp;
	logic [fbuf_pkg::ADDR_W-1:0] last_addr;

	logic [NUM_READERS-1:0]      r_sof;
	logic [fbuf_pkg::ADDR_W-1:0] r_addr_q [NUM_READERS];
	fbuf_pkg::bmp_t              r_bmp_q [NUM_READERS];

	fbuf_pkg::bmp_t              held;
	fbuf_pkg::bmp_t              free_bmp;
	logic [IDX_W-1:0]            free_idx;

	// Slot base is index times frame length
	function automatic logic [fbuf_pkg::ADDR_W-1:0] base_of(input logic [IDX_W-1:0] idx);
		base_of = fbuf_pkg::ADDR_W'(int'(idx) * FRAME_WORDS);
	endfunction

	assign r_sof = {r1_sof, r0_sof};

	assign r0_addr = r_addr_q[0];
	assign r1_addr = r_addr_q[1];

	//////////////////////////////
	// Free buffer search
	//////////////////////////////

	// Walk downward so the lowest free buffer wins
	always_comb begin
		held     = w_bmp | r_bmp_q[0] | r_bmp_q[1];
		free_bmp = '0;
		free_idx = '0;
		for (int i = fbuf_pkg::NUM_BUFS - 1; i >= 0; i--) begin
			if (!held[i]) begin
				free_bmp = fbuf_pkg::bmp_t'(1) << i;
				free_idx = IDX_W'(i);
			end
		end
	end

	//////////////////////////////
	// Writer and last frame
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			w_addr    <= '0;
			w_bmp     <= '0;
			last_addr <= '0;
			last_bmp  <= '0;
		end else if (w_sof) begin
			// Frame in the writer buffer is now complete
			last_addr <= w_addr;
			last_bmp  <= w_bmp;
			w_addr    <= base_of(free_idx);
			w_bmp     <= free_bmp;
		end
	end

	//////////////////////////////
	// Readers
	//////////////////////////////

	always_ff @(posedge clk) begin
		for (int n = 0; n < NUM_READERS; n++) begin
			if (!resetn) begin
				r_addr_q[n] <= '0;
				r_bmp_q[n]  <= '0;
			end else if (r_sof[n]) begin
				// Same cycle as w_sof means the writer buffer just finished
				if (w_sof) begin
					r_addr_q[n] <= w_addr;
					r_bmp_q[n]  <= w_bmp;
				end else begin
					r_addr_q[n] <= last_addr;
					r_bmp_q[n]  <= last_bmp;
				end
			end
		end
	end

endmodule

//--- hdl/frame_writer.sv
`timescale 1ns/1ps

module frame_writer #(
	parameter int FRAME_WORDS = 16
) (
	input  logic                        clk,
	input  logic                        resetn,

	input  logic                        in_sof,
	input  logic                        in_valid,
	input  logic [fbuf_pkg::DATA_W-1:0] in_data,

	input  logic [fbuf_pkg::ADDR_W-1:0] w_addr,
	input  logic                        grant,

	output logic                        req,
	output logic [fbuf_pkg::ADDR_W-1:0] mem_addr,
	output logic [fbuf_pkg::DATA_W-1:0] mem_wdata
);

	localparam logic [fbuf_pkg::ADDR_W-1:0] FRAME_LEN = fbuf_pkg::ADDR_W'(FRAME_WORDS);

	logic [fbuf_pkg::ADDR_W-1:0] count;
	logic [fbuf_pkg::ADDR_W-1:0] pix_idx;
	logic                        take;

	// Pixels past the end of the slot are dropped
	assign take = in_valid && (in_sof || count < FRAME_LEN);

	// Base is read live so the first word sees the new buffer
	assign mem_addr = w_addr + pix_idx;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			req   <= 1'b0;
			count <= '0;
		end else begin
			if (grant) begin
				req <= 1'b0;
			end
			if (take) begin
				req <= 1'b1;
				if (in_sof) begin
					count <= fbuf_pkg::ADDR_W'(1);
				end else begin
					count <= count + 1'b1;
				end
			end
		end
	end

	// Pending word
	always_ff @(posedge clk) begin
		if (take) begin
			mem_wdata <= in_data;
			pix_idx   <= in_sof ? '0 : count;
		end
	end

endmodule

//--- hdl/frame_reader.sv
`timescale 1ns/1ps

module frame_reader #(
	parameter int FRAME_WORDS = 16
) (
	input  logic                        clk,
	input  logic                        resetn,

	input  logic                        rd_sof,
	input  logic [fbuf_pkg::ADDR_W-1:0] r_addr,

	input  logic                        grant,
	input  logic                        rvalid,
	input  logic [fbuf_pkg::DATA_W-1:0] rdata,

	output logic                        req,
	output logic [fbuf_pkg::ADDR_W-1:0] mem_addr,

	output logic                        out_valid,
	output logic [fbuf_pkg::DATA_W-1:0] out_data,
	output logic                        out_last
);

	localparam logic [fbuf_pkg::ADDR_W-1:0] LAST_IDX = fbuf_pkg::ADDR_W'(FRAME_WORDS - 1);

	logic                        active;
	logic                        ignore;
	logic                        accept;
	logic [fbuf_pkg::ADDR_W-1:0] issue_cnt;
	logic [fbuf_pkg::ADDR_W-1:0] recv_cnt;

	assign req      = active;
	assign mem_addr = r_addr + issue_cnt;

	// Returns in the sof cycle and the one after belong to the aborted read
	assign accept = rvalid && !rd_sof && !ignore;

	//////////////////////////////
	// Issue side
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			active    <= 1'b0;
			ignore    <= 1'b0;
			issue_cnt <= '0;
		end else begin
			ignore <= rd_sof;
			if (rd_sof) begin
				active    <= 1'b0;
				issue_cnt <= '0;
			end else if (ignore) begin
				// r_addr holds the new buffer by now
				active <= 1'b1;
			end else if (grant) begin
				if (issue_cnt == LAST_IDX) begin
					active <= 1'b0;
				end else begin
					issue_cnt <= issue_cnt + 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// Receive side
	//////////////////////////////

	always_ff @(posedge clk) begin
		if (!resetn) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
			recv_cnt  <= '0;
		end else begin
			out_valid <= accept;
			out_last  <= accept && recv_cnt == LAST_IDX;
			if (rd_sof) begin
				recv_cnt <= '0;
			end else if (accept) begin
				recv_cnt <= (recv_cnt == LAST_IDX) ? '0 : recv_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_data <= rdata;
		end
	end

endmodule

//--- hdl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                           clk,
	input  logic                           resetn,

	input  logic [fbuf_pkg::NUM_PORTS-1:0] req,

	input  logic [fbuf_pkg::ADDR_W-1:0]    w_addr,
	input  logic [fbuf_pkg::DATA_W-1:0]    w_wdata,
	input  logic [fbuf_pkg::ADDR_W-1:0]    r0_addr,
	input  logic [fbuf_pkg::ADDR_W-1:0]    r1_addr,

	output logic [fbuf_pkg::NUM_PORTS-1:0] grant,
	output logic [fbuf_pkg::NUM_PORTS-1:0] rvalid,

	output logic [fbuf_pkg::ADDR_W-1:0]    mem_addr,
	output logic [fbuf_pkg::DATA_W-1:0]    mem_wdata,
	output logic                           mem_we
);

	fbuf_pkg::port_id_t last_q;
	fbuf_pkg::port_id_t sel;
	fbuf_pkg::port_id_t rd_port_q;
	logic               rd_pend_q;

	// Round robin starting after the last granted port
	always_comb begin
		int p;
		grant = '0;
		sel   = last_q;
		for (int k = fbuf_pkg::NUM_PORTS; k >= 1; k--) begin
			p = (int'(last_q) + k) % fbuf_pkg::NUM_PORTS;
			if (req[p]) begin
				grant    = '0;
				grant[p] = 1'b1;
				sel      = fbuf_pkg::port_id_t'(p);
			end
		end
	end

	// Memory port follows the granted client
	always_comb begin
		case (sel)
			fbuf_pkg::READER0: mem_addr = r0_addr;
			fbuf_pkg::READER1: mem_addr = r1_addr;
			default:           mem_addr = w_addr;
		endcase
		mem_we    = grant[fbuf_pkg::WRITER];
		mem_wdata = w_wdata;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			last_q    <= fbuf_pkg::READER1;
			rd_port_q <= fbuf_pkg::READER0;
			rd_pend_q <= 1'b0;
		end else begin
			rd_pend_q <= (|grant) && sel != fbuf_pkg::WRITER;
			rd_port_q <= sel;
			if (|grant) begin
				last_q <= sel;
			end
		end
	end

	// Read data lands one cycle after the grant
	always_comb begin
		rvalid = '0;
		rvalid[rd_port_q] = rd_pend_q;
	end

endmodule

//--- hdl/frame_mem.sv
`timescale 1ns/1ps

module frame_mem #(
	parameter int DEPTH = 64
) (
	input  logic                        clk,
	input  logic [fbuf_pkg::ADDR_W-1:0] addr,
	input  logic [fbuf_pkg::DATA_W-1:0] wdata,
	input  logic                        we,
	output logic [fbuf_pkg::DATA_W-1:0] rdata
);

	localparam int AW = $clog2(DEPTH);

	logic [fbuf_pkg::DATA_W-1:0] mem [DEPTH];

	// Read returns the old word on a same-address write
	always_ff @(posedge clk) begin
		if (we) begin
			mem[addr[AW-1:0]] <= wdata;
		end
		rdata <= mem[addr[AW-1:0]];
	end

endmodule

//--- hdl/frame_buffer_top.sv
`timescale 1ns/1ps

module frame_buffer_top #(
	parameter int FRAME_WORDS = 16
) (
	input  logic                        clk,
	input  logic                        resetn,

	input  logic                        in_sof,
	input  logic                        in_valid,
	input  logic [fbuf_pkg::DATA_W-1:0] in_data,

	input  logic                        rd0_sof,
	output logic                        out0_valid,
	output logic [fbuf_pkg::DATA_W-1:0] out0_data,
	output logic                        out0_last,

	input  logic                        rd1_sof,
	output logic                        out1_valid,
	output logic [fbuf_pkg::DATA_W-1:0] out1_data,
	output logic                        out1_last
);

	// Buffer bases from the controller
	logic [fbuf_pkg::ADDR_W-1:0]    buf_w_addr;
	logic [fbuf_pkg::ADDR_W-1:0]    buf_r0_addr;
	logic [fbuf_pkg::ADDR_W-1:0]    buf_r1_addr;

	// Client side of the arbiter
	logic [fbuf_pkg::NUM_PORTS-1:0] req;
	logic [fbuf_pkg::NUM_PORTS-1:0] grant;
	logic [fbuf_pkg::NUM_PORTS-1:0] rvalid;
	logic [fbuf_pkg::ADDR_W-1:0]    wr_addr;
	logic [fbuf_pkg::DATA_W-1:0]    wr_data;
	logic [fbuf_pkg::ADDR_W-1:0]    rd0_addr;
	logic [fbuf_pkg::ADDR_W-1:0]    rd1_addr;

	// Memory port
	logic [fbuf_pkg::ADDR_W-1:0]    mem_addr;
	logic [fbuf_pkg::DATA_W-1:0]    mem_wdata;
	logic [fbuf_pkg::DATA_W-1:0]    mem_rdata;
	logic                           mem_we;

	mutex_buffer_ctl #(
		.FRAME_WORDS(FRAME_WORDS)
	) mutex_buffer_ctl_inst (
		.clk(clk),
		.resetn(resetn),
		.w_sof(in_sof),
		.r0_sof(rd0_sof),
		.r1_sof(rd1_sof),
		.w_addr(buf_w_addr),
		.r0_addr(buf_r0_addr),
		.r1_addr(buf_r1_addr)
	);

	frame_writer #(
		.FRAME_WORDS(FRAME_WORDS)
	) frame_writer_inst (
		.clk(clk),
		.resetn(resetn),
		.in_sof(in_sof),
		.in_valid(in_valid),
		.in_data(in_data),
		.w_addr(buf_w_addr),
		.grant(grant[fbuf_pkg::WRITER]),
		.req(req[fbuf_pkg::WRITER]),
		.mem_addr(wr_addr),
		.mem_wdata(wr_data)
	);

	frame_reader #(
		.FRAME_WORDS(FRAME_WORDS)
	) reader0 (
		.clk(clk),
		.resetn(resetn),
		.rd_sof(rd0_sof),
		.r_addr(buf_r0_addr),
		.grant(grant[fbuf_pkg::READER0]),
		.rvalid(rvalid[fbuf_pkg::READER0]),
		.rdata(mem_rdata),
		.req(req[fbuf_pkg::READER0]),
		.mem_addr(rd0_addr),
		.out_valid(out0_valid),
		.out_data(out0_data),
		.out_last(out0_last)
	);

	frame_reader #(
		.FRAME_WORDS(FRAME_WORDS)
	) reader1 (
		.clk(clk),
		.resetn(resetn),
		.rd_sof(rd1_sof),
		.r_addr(buf_r1_addr),
		.grant(grant[fbuf_pkg::READER1]),
		.rvalid(rvalid[fbuf_pkg::READER1]),
		.rdata(mem_rdata),
		.req(req[fbuf_pkg::READER1]),
		.mem_addr(rd1_addr),
		.out_valid(out1_valid),
		.out_data(out1_data),
		.out_last(out1_last)
	);

	mem_arbiter mem_arbiter_inst (
		.clk(clk),
		.resetn(resetn),
		.req(req),
		.w_addr(wr_addr),
		.w_wdata(wr_data),
		.r0_addr(rd0_addr),
		.r1_addr(rd1_addr),
		.grant(grant),
		.rvalid(rvalid),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_we(mem_we)
	);

	frame_mem #(
		.DEPTH(fbuf_pkg::NUM_BUFS * FRAME_WORDS)
	) frame_mem_inst (
		.clk(clk),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.we(mem_we),
		.rdata(mem_rdata)
	);

endmodule

//--- verification/tb_frame_buffer.sv
`timescale 1ns/1ps

module tb_frame_buffer;

	localparam int FRAME_WORDS    = 16;
	localparam int TIMEOUT_CYCLES = 6000;

	logic                        clk;
	logic                        resetn;
	logic                        in_sof;
	logic                        in_valid;
	logic [fbuf_pkg::DATA_W-1:0] in_data;
	logic                        rd0_sof;
	logic                        rd1_sof;
	logic                        out0_valid;
	logic [fbuf_pkg::DATA_W-1:0] out0_data;
	logic                        out0_last;
	logic                        out1_valid;
	logic [fbuf_pkg::DATA_W-1:0] out1_data;
	logic                        out1_last;

	logic [31:0] rng;
	string       test_name;
	int          cycles = 0;

	// Frame numbers as the buffer controller should track them
	logic [7:0] wr_frame;
	logic [7:0] last_frame;

	// Scoreboard state, one entry per reader
	logic [1:0]                  rd_sof_v;
	logic [1:0]                  out_valid_v;
	logic [1:0]                  out_last_v;
	logic [fbuf_pkg::DATA_W-1:0] out_data_v [2];
	logic [fbuf_pkg::DATA_W-1:0] exp_word [2];
	logic [7:0]                  exp_frame [2];
	int                          rx_idx [2];
	int                          remaining [2];

	frame_buffer_top #(
		.FRAME_WORDS(FRAME_WORDS)
	) frame_buffer_top_inst (
		.clk(clk),
		.resetn(resetn),
		.in_sof(in_sof),
		.in_valid(in_valid),
		.in_data(in_data),
		.rd0_sof(rd0_sof),
		.out0_valid(out0_valid),
		.out0_data(out0_data),
		.out0_last(out0_last),
		.rd1_sof(rd1_sof),
		.out1_valid(out1_valid),
		.out1_data(out1_data),
		.out1_last(out1_last)
	);

	always #5 clk = ~clk;

	always_comb begin
		rd_sof_v      = {rd1_sof, rd0_sof};
		out_valid_v   = {out1_valid, out0_valid};
		out_last_v    = {out1_last, out0_last};
		out_data_v[0] = out0_data;
		out_data_v[1] = out1_data;
		// Pixel value is frame number over pixel index
		for (int n = 0; n < 2; n++) begin
			exp_word[n] = {exp_frame[n], rx_idx[n][7:0]};
		end
	end

	//////////////////////////////
	// Reference model
	//////////////////////////////

	always @(posedge clk) begin
		if (!resetn) begin
			wr_frame   <= '0;
			last_frame <= '0;
		end else if (in_sof) begin
			last_frame <= wr_frame;
			wr_frame   <= in_data[fbuf_pkg::DATA_W-1 -: 8];
		end
		for (int n = 0; n < 2; n++) begin
			if (!resetn) begin
				rx_idx[n]    <= 0;
				remaining[n] <= 0;
				exp_frame[n] <= '0;
			end else begin
				if (out_valid_v[n]) begin
					rx_idx[n]    <= rx_idx[n] + 1;
					remaining[n] <= remaining[n] - 1;
				end
				// Restart wins over a word in the same cycle
				if (rd_sof_v[n]) begin
					rx_idx[n]    <= 0;
					remaining[n] <= FRAME_WORDS;
					// With a writer sof alongside, the frame just finished
					exp_frame[n] <= in_sof ? wr_frame : last_frame;
				end
			end
		end
	end

	//////////////////////////////
	// Output checks
	//////////////////////////////

	for (genvar n = 0; n < 2; n++) begin : g_reader_check
		assert property (@(posedge clk) disable iff (!resetn)
			(out_valid_v[n] || out_last_v[n]) |-> (out_valid_v[n] && remaining[n] != 0))
		else begin
			$display("Reader %0d produced output while no frame was being read", n);
			$display("Test failed");
			$fatal(1);
		end

		assert property (@(posedge clk) disable iff (!resetn)
			out_valid_v[n] |-> out_data_v[n] == exp_word[n])
		else begin
			$display("Mismatch in %s, reader %0d data: expected %h, actual %h",
				test_name, n, $sampled(exp_word[n]), $sampled(out_data_v[n]));
			$display("Test failed");
			$fatal(1);
		end

		assert property (@(posedge clk) disable iff (!resetn)
			out_valid_v[n] |-> out_last_v[n] == (rx_idx[n] == FRAME_WORDS - 1))
		else begin
			$display("Mismatch in %s, reader %0d last: expected %0b, actual %0b",
				test_name, n, $sampled(rx_idx[n] == FRAME_WORDS - 1), $sampled(out_last_v[n]));
			$display("Test failed");
			$fatal(1);
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles in %s", TIMEOUT_CYCLES, test_name);
			$display("Test failed");
			$fatal(1);
		end
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic logic [31:0] next_rand(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic pulse_readers(input logic [1:0] mask);
		rd0_sof = mask[0];
		rd1_sof = mask[1];
		step();
		rd0_sof = 1'b0;
		rd1_sof = 1'b0;
	endtask

	task automatic wait_frames(input logic [1:0] mask);
		while ((mask[0] && remaining[0] != 0) || (mask[1] && remaining[1] != 0)) begin
			step();
		end
	endtask

	// One full frame, 4 to 7 cycles between pixels
	task automatic write_frame(input int fnum);
		int gap;
		for (int i = 0; i < FRAME_WORDS; i++) begin
			in_valid = 1'b1;
			in_sof   = (i == 0);
			in_data  = {fnum[7:0], i[7:0]};
			step();
			in_valid = 1'b0;
			in_sof   = 1'b0;
			rng      = next_rand(rng);
			gap      = 4 + int'(rng[17:16]);
			repeat (gap - 1) step();
		end
	endtask

	initial begin
		int offset;
		clk       = 1'b0;
		resetn    = 1'b0;
		in_sof    = 1'b0;
		in_valid  = 1'b0;
		in_data   = '0;
		rd0_sof   = 1'b0;
		rd1_sof   = 1'b0;
		rng       = 32'hf06d7f25;
		test_name = "reset";
		repeat (2) @(posedge clk);
		#1;
		resetn = 1'b1;

		test_name = "idle after reset";
		repeat (30) step();

		test_name = "first frame read";
		write_frame(1);
		fork
			write_frame(2);
			begin
				repeat (3) step();
				pulse_readers(2'b01);
				wait_frames(2'b01);
			end
		join

		// Reader 1 must get frame 4, the newest one
		test_name = "latest frame";
		write_frame(3);
		write_frame(4);
		fork
			write_frame(5);
			begin
				repeat (5) step();
				pulse_readers(2'b10);
				wait_frames(2'b10);
			end
		join

		test_name = "mutual exclusion";
		fork
			write_frame(6);
			begin
				repeat (2) step();
				pulse_readers(2'b01);
				wait_frames(2'b01);
			end
		join
		// Offset zero lands on the writer sof
		for (int f = 7; f <= 9; f++) begin
			rng    = next_rand(rng);
			offset = 2 * int'(rng[20:16]);
			fork
				write_frame(f);
				begin
					repeat (offset) step();
					pulse_readers(2'b01);
					wait_frames(2'b01);
				end
			join
		end

		test_name = "simultaneous sof";
		fork
			write_frame(10);
			begin
				pulse_readers(2'b11);
				wait_frames(2'b11);
			end
		join

		test_name = "mid-frame restart";
		pulse_readers(2'b01);
		while (remaining[0] > 9) begin
			step();
		end
		pulse_readers(2'b01);
		wait_frames(2'b01);
		repeat (10) step();

		$display("Test passed");
		$finish;
	end

endmodule

//--- frame_buffer.f
hdl/fbuf_pkg.sv
hdl/mutex_buffer_ctl.sv
hdl/frame_writer.sv
hdl/frame_reader.sv
hdl/mem_arbiter.sv
hdl/frame_mem.sv
hdl/frame_buffer_top.sv
verification/tb_frame_buffer.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_frame_buffer
FILELIST  := frame_buffer.f
FLAGS     := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
PASS_MSG  := Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Output goes to the terminal and is searched for the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
